// ==== list.f ====
design/cachePkg.sv
design/cacheTagStore.sv
design/cacheDataStore.sv
design/cacheLookup.sv
design/cacheRefill.sv
design/cacheTop.sv
tb/cacheTb.sv

// ==== tb/cacheTb.sv ====
module cacheTb;
  import cachePkg::*;

  localparam int PERIOD = 40;
  localparam int RAND_N = 300;
  localparam int NUM_REQ = RAND_N + 20;
  // miss path plus memory gap, with slack for the idle cycle between requests
  localparam int WORST_MISS = 24;
  localparam int TIMEOUT_CYCLES = NUM_REQ * WORST_MISS + 100;

  logic clk;
  logic rst_n;
  logic [ADDR_W-1:0] addr_i;
  logic valid_i;
  logic addrOk_o;
  logic dataOk_o;
  logic dataNotOk_o;
  logic [XLEN-1:0] rdData_o;
  logic memRdReq_o;
  logic [ADDR_W-1:0] memAddr_o;
  logic [XLEN-1:0] memRdData_i;
  logic memRdBeat_i;
  logic memRdLast_i;

  // outstanding requests, oldest first
  logic [ADDR_W-1:0] qAddr[$];
  logic qHit[$];
  int qCycle[$];
  int qReqCnt[$];

  // shadow copy of tags, valid and lru bits
  logic [TAG_W-1:0] shTag [WAYS][SETS];
  logic shValid [WAYS][SETS];
  logic shLru [SETS];

  logic [31:0] lfsr = 32'hafca;
  int cycle = 0;
  int reqCount = 0;
  int errors = 0;
  int checks = 0;
  int errStart = 0;
  string curTest = "reset";

  cacheTop i_dut (
    .clk(clk), .rst_n(rst_n), .addr_i(addr_i), .valid_i(valid_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .dataNotOk_o(dataNotOk_o),
    .rdData_o(rdData_o), .memRdReq_o(memRdReq_o), .memAddr_o(memAddr_o),
    .memRdData_i(memRdData_i), .memRdBeat_i(memRdBeat_i), .memRdLast_i(memRdLast_i)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
    return bits;
  endfunction

  // memory contents, a pure function of the word address
  function automatic logic [XLEN-1:0] memWord(input logic [ADDR_W-1:0] a);
    logic [31:0] wa;
    wa = {3'b000, a[ADDR_W-1:3]};
    return {wa ^ 32'hc3a5_5a3c, (wa * 32'h9e37_79b9) ^ 32'h0f0f_1234};
  endfunction

  // expected hit or miss; updates the shadow state like the cache would
  function automatic logic refAccess(input logic [ADDR_W-1:0] a);
    logic [TAG_W-1:0] tag;
    logic [INDEX_W-1:0] idx;
    logic way;
    logic hit;
    tag = a[TAG_LSB +: TAG_W];
    idx = a[INDEX_LSB +: INDEX_W];
    hit = 1'b1;
    if (shValid[0][idx] && shTag[0][idx] == tag) begin
      way = 1'b0;
    end else if (shValid[1][idx] && shTag[1][idx] == tag) begin
      way = 1'b1;
    end else begin
      hit = 1'b0;
      // invalid ways first, then the lru way
      if (!shValid[0][idx]) begin
        way = 1'b0;
      end else if (!shValid[1][idx]) begin
        way = 1'b1;
      end else begin
        way = shLru[idx];
      end
      shValid[way][idx] = 1'b1;
      shTag[way][idx] = tag;
    end
    shLru[idx] = ~way;
    return hit;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
      errors++;
    end
  endtask

  // drive one request and wait until it is accepted
  task automatic issue(input logic [ADDR_W-1:0] a, input int gap);
    @(negedge clk);
    valid_i = 1'b1;
    addr_i = a;
    @(posedge clk);
    while (!addrOk_o) @(posedge clk);
    qHit.push_back(refAccess(a));
    qAddr.push_back(a);
    qCycle.push_back(cycle);
    qReqCnt.push_back(reqCount);
    if (gap > 0) begin
      @(negedge clk);
      valid_i = 1'b0;
      repeat (gap - 1) @(negedge clk);
    end
  endtask

  task automatic stopIssue();
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  task automatic startTest(input string name);
    curTest = name;
    errStart = errors;
  endtask

  task automatic finishTest();
    while (qAddr.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("test %s finished with %0d errors", curTest, errors - errStart);
  endtask

  // burst memory, answers each line request after a random gap
  initial begin : memModel
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] lineAddr;
    int gapCycles;
    memRdData_i = '0;
    memRdBeat_i = 1'b0;
    memRdLast_i = 1'b0;
    forever begin
      @(posedge clk);
      if (memRdReq_o) begin
        base = memAddr_o;
        reqCount <= reqCount + 1;
        assert (qAddr.size() != 0) else begin
          $display("memory request at %0t with no request outstanding", $time);
          errors++;
        end
        if (qAddr.size() != 0) begin
          // start of the 32-byte line that holds the request
          lineAddr = (qAddr[0] / (LINE_W / 8)) * (LINE_W / 8);
          assert (base === lineAddr) else begin
            $display("FAILED at %0t: memAddr_o got %h expected %h", $time, base,
                     lineAddr);
            errors++;
          end
        end
        gapCycles = 1 + (takeBits(2) % 3);
        repeat (gapCycles) @(negedge clk);
        for (int b = 0; b < BEATS; b++) begin
          memRdBeat_i = 1'b1;
          memRdData_i = memWord(base + b * (XLEN / 8));
          memRdLast_i = (b == BEATS - 1);
          @(negedge clk);
        end
        memRdBeat_i = 1'b0;
        memRdLast_i = 1'b0;
      end
    end
  end

  // every response against the oldest outstanding request
  always @(posedge clk) begin : compareResp
    logic [ADDR_W-1:0] a;
    logic expHit;
    int accCycle;
    int accReq;
    if (rst_n) begin
      assert (addrOk_o !== dataNotOk_o) else begin
        $display("FAILED at %0t: addrOk_o got %0b expected %0b", $time, addrOk_o, !dataNotOk_o);
        errors++;
      end
      if (dataOk_o) begin
        assert (qAddr.size() != 0) else begin
          $display("dataOk_o pulsed at %0t with no request outstanding", $time);
          errors++;
        end
        if (qAddr.size() != 0) begin
          a = qAddr.pop_front();
          expHit = qHit.pop_front();
          accCycle = qCycle.pop_front();
          accReq = qReqCnt.pop_front();
          checks++;
          assert (rdData_o === memWord(a)) else begin
            $display("FAILED at %0t: rdData_o got %h expected %h", $time, rdData_o, memWord(a));
            errors++;
          end
          assert ((reqCount - accReq) == (expHit ? 0 : 1)) else begin
            $display("FAILED at %0t: memRdReq_o pulses got %0d expected %0d", $time,
                     reqCount - accReq, expHit ? 0 : 1);
            errors++;
          end
          if (expHit) begin
            assert (cycle == accCycle + 1) else begin
              $display("FAILED at %0t: dataOk_o latency got %0d expected 1", $time,
                       cycle - accCycle);
              errors++;
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * PERIOD);
    $display("watchdog: test %s did not finish in time", curTest);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] lineC;
    logic [31:0] r;
    int firstAcc;
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    for (int s = 0; s < SETS; s++) begin
      shValid[0][s] = 1'b0;
      shValid[1][s] = 1'b0;
      shLru[s] = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    startTest("afterReset");
    @(posedge clk);
    checkBit("addrOk_o", addrOk_o, 1'b1);
    checkBit("dataOk_o", dataOk_o, 1'b0);
    checkBit("dataNotOk_o", dataNotOk_o, 1'b0);
    checkBit("memRdReq_o", memRdReq_o, 1'b0);
    issue(32'h0004_2a48, 1);
    finishTest();

    startTest("missThenHit");
    issue(32'h0013_5c60, 1);
    issue(32'h0013_5c78, 1);
    finishTest();

    // first a miss to bring the line in, then four words back to back
    startTest("wordSelect");
    lineC = 32'h0200_7f80;
    issue(lineC, 0);
    issue(lineC, 0);
    firstAcc = cycle;
    issue(lineC + 8, 0);
    issue(lineC + 16, 0);
    issue(lineC + 24, 0);
    assert (cycle - firstAcc == 3) else begin
      $display("FAILED at %0t: accept cycles got %0d expected 3", $time, cycle - firstAcc);
      errors++;
    end
    stopIssue();
    finishTest();

    // three tags in set 5
    startTest("replacement");
    issue({21'h00a11, 6'd5, 5'd0}, 1);
    issue({21'h00b22, 6'd5, 5'd0}, 1);
    issue({21'h00a11, 6'd5, 5'd8}, 1);
    issue({21'h00c33, 6'd5, 5'd0}, 1);
    issue({21'h00a11, 6'd5, 5'd16}, 1);
    issue({21'h00b22, 6'd5, 5'd0}, 1);
    finishTest();

    // top bit picks an idle cycle or a back-to-back request
    startTest("randomStream");
    for (int n = 0; n < RAND_N; n++) begin
      r = takeBits(7);
      issue({19'h2b1c3, r[5:4], 4'b0011, r[3:2], r[1:0], 3'b000}, r[6]);
    end
    stopIssue();
    finishTest();

    $display("%0d responses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== design/cacheTop.sv ====
module cacheTop (
  input  logic                          clk,
  input  logic                          rst_n,
  // processor load port
  input  logic [cachePkg::ADDR_W-1:0]   addr_i,
  input  logic                          valid_i,
  output logic                          addrOk_o,
  output logic                          dataOk_o,
  output logic                          dataNotOk_o,
  output logic [cachePkg::XLEN-1:0]     rdData_o,
  // burst read port toward memory
  output logic                          memRdReq_o,
  output logic [cachePkg::ADDR_W-1:0]   memAddr_o,
  input  logic [cachePkg::XLEN-1:0]     memRdData_i,
  input  logic                          memRdBeat_i,
  input  logic                          memRdLast_i
);
  import cachePkg::*;

  logic                 rdEn;
  logic [INDEX_W-1:0]   rdIndex;
  logic [TAG_W-1:0]     tagWay0;
  logic [TAG_W-1:0]     tagWay1;
  logic                 validWay0;
  logic                 validWay1;
  logic                 lruWay;
  logic [LINE_W-1:0]    lineWay0;
  logic [LINE_W-1:0]    lineWay1;
  logic                 hitStrobe;
  logic                 hitWay;
  logic                 missStrobe;
  logic [ADDR_W-1:0]    missAddr;
  logic                 missVictim;
  logic                 fillEn;
  logic                 fillWay;
  logic [INDEX_W-1:0]   fillIndex;
  logic [TAG_W-1:0]     fillTag;
  logic [LINE_W-1:0]    fillLine;
  logic                 replay;

  cacheLookup i_lookup (
    .clk(clk), .rst_n(rst_n), .addr_i(addr_i), .valid_i(valid_i),
    .tagWay0_i(tagWay0), .tagWay1_i(tagWay1), .validWay0_i(validWay0),
    .validWay1_i(validWay1), .lruWay_i(lruWay), .lineWay0_i(lineWay0),
    .lineWay1_i(lineWay1), .replay_i(replay), .addrOk_o(addrOk_o),
    .dataOk_o(dataOk_o), .dataNotOk_o(dataNotOk_o), .rdData_o(rdData_o),
    .rdEn_o(rdEn), .rdIndex_o(rdIndex), .hitStrobe_o(hitStrobe), .hitWay_o(hitWay),
    .missStrobe_o(missStrobe), .missAddr_o(missAddr), .missVictim_o(missVictim)
  );

  cacheTagStore i_tagStore (
    .clk(clk), .rst_n(rst_n), .rdEn_i(rdEn), .rdIndex_i(rdIndex),
    .hitStrobe_i(hitStrobe), .hitWay_i(hitWay), .fillEn_i(fillEn),
    .fillWay_i(fillWay), .fillIndex_i(fillIndex), .fillTag_i(fillTag),
    .tagWay0_o(tagWay0), .tagWay1_o(tagWay1), .validWay0_o(validWay0),
    .validWay1_o(validWay1), .lruWay_o(lruWay)
  );

  cacheDataStore i_dataStore (
    .clk(clk), .rdEn_i(rdEn), .rdIndex_i(rdIndex), .fillEn_i(fillEn),
    .fillWay_i(fillWay), .fillIndex_i(fillIndex), .fillLine_i(fillLine),
    .lineWay0_o(lineWay0), .lineWay1_o(lineWay1)
  );

  cacheRefill i_refill (
    .clk(clk), .rst_n(rst_n), .missStrobe_i(missStrobe), .missAddr_i(missAddr),
    .missVictim_i(missVictim), .memRdData_i(memRdData_i), .memRdBeat_i(memRdBeat_i),
    .memRdLast_i(memRdLast_i), .memRdReq_o(memRdReq_o), .memAddr_o(memAddr_o),
    .fillEn_o(fillEn), .fillWay_o(fillWay), .fillIndex_o(fillIndex),
    .fillTag_o(fillTag), .fillLine_o(fillLine), .replay_o(replay)
  );

endmodule

// ==== design/cacheRefill.sv ====
module cacheRefill (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          missStrobe_i,
  input  logic [cachePkg::ADDR_W-1:0]   missAddr_i,
  input  logic                          missVictim_i,
  input  logic [cachePkg::XLEN-1:0]     memRdData_i,
  input  logic                          memRdBeat_i,
  input  logic                          memRdLast_i,
  output logic                          memRdReq_o,
  output logic [cachePkg::ADDR_W-1:0]   memAddr_o,
  output logic                          fillEn_o,
  output logic                          fillWay_o,
  output logic [cachePkg::INDEX_W-1:0]  fillIndex_o,
  output logic [cachePkg::TAG_W-1:0]    fillTag_o,
  output logic [cachePkg::LINE_W-1:0]   fillLine_o,
  output logic                          replay_o
);
  import cachePkg::*;

  logic [1:0]          state;
  logic [1:0]          stateNext;
  logic [ADDR_W-1:0]   missAddrQ;
  logic                victimQ;
  logic [LINE_W-1:0]   lineBuf;

  always_comb begin
    stateNext = state;
    case (state)
      RF_IDLE: begin
        if (missStrobe_i) begin
          stateNext = RF_REQUEST;
        end
      end
      RF_REQUEST: begin
        stateNext = RF_COLLECT;
      end
      RF_COLLECT: begin
        if (memRdBeat_i && memRdLast_i) begin
          stateNext = RF_WRITE;
        end
      end
      RF_WRITE: begin
        stateNext = RF_IDLE;
      end
      default: begin
        stateNext = RF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RF_IDLE;
      replay_o <= 1'b0;
    end else begin
      state <= stateNext;
      // replay follows the line write by one cycle
      replay_o <= (state == RF_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    if (missStrobe_i && (state == RF_IDLE)) begin
      missAddrQ <= missAddr_i;
      victimQ <= missVictim_i;
    end
    // beats enter at the top, first beat ends in the lowest word
    if ((state == RF_COLLECT) && memRdBeat_i) begin
      lineBuf <= {memRdData_i, lineBuf[LINE_W-1:XLEN]};
    end
  end

  assign memRdReq_o = (state == RF_REQUEST);
  assign memAddr_o = {missAddrQ[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  assign fillEn_o = (state == RF_WRITE);
  assign fillWay_o = victimQ;
  assign fillIndex_o = missAddrQ[INDEX_LSB +: INDEX_W];
  assign fillTag_o = missAddrQ[TAG_LSB +: TAG_W];
  assign fillLine_o = lineBuf;

endmodule

// ==== design/cacheLookup.sv ====
module cacheLookup (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cachePkg::ADDR_W-1:0]   addr_i,
  input  logic                          valid_i,
  input  logic [cachePkg::TAG_W-1:0]    tagWay0_i,
  input  logic [cachePkg::TAG_W-1:0]    tagWay1_i,
  input  logic                          validWay0_i,
  input  logic                          validWay1_i,
  input  logic                          lruWay_i,
  input  logic [cachePkg::LINE_W-1:0]   lineWay0_i,
  input  logic [cachePkg::LINE_W-1:0]   lineWay1_i,
  input  logic                          replay_i,
  output logic                          addrOk_o,
  output logic                          dataOk_o,
  output logic                          dataNotOk_o,
  output logic [cachePkg::XLEN-1:0]     rdData_o,
  output logic                          rdEn_o,
  output logic [cachePkg::INDEX_W-1:0]  rdIndex_o,
  output logic                          hitStrobe_o,
  output logic                          hitWay_o,
  output logic                          missStrobe_o,
  output logic [cachePkg::ADDR_W-1:0]   missAddr_o,
  output logic                          missVictim_o
);
  import cachePkg::*;

  logic [1:0]                  state;
  logic [1:0]                  stateNext;
  logic [ADDR_W-1:0]           reqLatch;
  logic [TAG_W-1:0]            reqTag;
  logic [$clog2(BEATS)-1:0]    wordSel;
  logic                        way0Hit;
  logic                        way1Hit;
  logic                        cacheHit;
  logic                        compareEn;
  logic                        accept;
  logic [LINE_W-1:0]           hitLine;

  assign reqTag = reqLatch[TAG_LSB +: TAG_W];
  assign wordSel = reqLatch[WORD_SEL_LSB +: $clog2(BEATS)];

  assign compareEn = (state == LK_COMPARE);
  assign way0Hit = validWay0_i && (tagWay0_i == reqTag);
  assign way1Hit = validWay1_i && (tagWay1_i == reqTag);
  assign cacheHit = way0Hit || way1Hit;

  // a new request may enter while the current one hits
  assign addrOk_o = (state == LK_IDLE) || (compareEn && cacheHit);
  assign accept = valid_i && addrOk_o;

  always_comb begin
    stateNext = state;
    case (state)
      LK_IDLE: begin
        if (accept) begin
          stateNext = LK_COMPARE;
        end
      end
      LK_COMPARE: begin
        if (!cacheHit) begin
          stateNext = LK_WAIT_FILL;
        end else if (!accept) begin
          stateNext = LK_IDLE;
        end
      end
      LK_WAIT_FILL: begin
        if (replay_i) begin
          stateNext = LK_COMPARE;
        end
      end
      default: begin
        stateNext = LK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= LK_IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= addr_i;
    end
  end

  // replay re-reads the latched set after the fill
  assign rdEn_o = accept || replay_i;
  assign rdIndex_o = replay_i ? reqLatch[INDEX_LSB +: INDEX_W] : addr_i[INDEX_LSB +: INDEX_W];

  // word select from the hitting way
  assign hitLine = way0Hit ? lineWay0_i : lineWay1_i;
  assign rdData_o = hitLine[wordSel*XLEN +: XLEN];

  assign dataOk_o = compareEn && cacheHit;
  assign dataNotOk_o = (compareEn && !cacheHit) || (state == LK_WAIT_FILL);
  assign hitStrobe_o = compareEn && cacheHit;
  assign hitWay_o = !way0Hit;

  // invalid ways are filled before lru picks
  assign missStrobe_o = compareEn && !cacheHit;
  assign missAddr_o = reqLatch;
  assign missVictim_o = !validWay0_i ? 1'b0 : (!validWay1_i ? 1'b1 : lruWay_i);

endmodule

// ==== design/cacheDataStore.sv ====
module cacheDataStore (
  input  logic                          clk,
  input  logic                          rdEn_i,
  input  logic [cachePkg::INDEX_W-1:0]  rdIndex_i,
  input  logic                          fillEn_i,
  input  logic                          fillWay_i,
  input  logic [cachePkg::INDEX_W-1:0]  fillIndex_i,
  input  logic [cachePkg::LINE_W-1:0]   fillLine_i,
  output logic [cachePkg::LINE_W-1:0]   lineWay0_o,
  output logic [cachePkg::LINE_W-1:0]   lineWay1_o
);
  import cachePkg::*;

  // one bank of lines per way
  logic [LINE_W-1:0] lineMem [WAYS][SETS];

  // whole-line write from the refill stage
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineMem[fillWay_i][fillIndex_i] <= fillLine_i;
    end
  end

  // both ways read together, compare picks one
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      lineWay0_o <= lineMem[0][rdIndex_i];
      lineWay1_o <= lineMem[1][rdIndex_i];
    end
  end

endmodule

// ==== design/cacheTagStore.sv ====
module cacheTagStore (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rdEn_i,
  input  logic [cachePkg::INDEX_W-1:0]  rdIndex_i,
  input  logic                          hitStrobe_i,
  input  logic                          hitWay_i,
  input  logic                          fillEn_i,
  input  logic                          fillWay_i,
  input  logic [cachePkg::INDEX_W-1:0]  fillIndex_i,
  input  logic [cachePkg::TAG_W-1:0]    fillTag_i,
  output logic [cachePkg::TAG_W-1:0]    tagWay0_o,
  output logic [cachePkg::TAG_W-1:0]    tagWay1_o,
  output logic                          validWay0_o,
  output logic                          validWay1_o,
  output logic                          lruWay_o
);
  import cachePkg::*;

  logic [TAG_W-1:0]              tagArr [WAYS][SETS];
  logic [SETS-1:0][WAYS-1:0]     validArr;
  // per set, the way to evict next
  logic [SETS-1:0]               lruArr;
  // set of the last read, which the hit update refers to
  logic [INDEX_W-1:0]            lastIndex;

  // tag write on fill, registered tag read
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillWay_i][fillIndex_i] <= fillTag_i;
    end
    if (rdEn_i) begin
      tagWay0_o <= tagArr[0][rdIndex_i];
      tagWay1_o <= tagArr[1][rdIndex_i];
      lastIndex <= rdIndex_i;
    end
  end

  // valid and lru bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      lruArr <= '0;
    end else begin
      if (fillEn_i) begin
        validArr[fillIndex_i][fillWay_i] <= 1'b1;
        // filled way becomes most recent
        lruArr[fillIndex_i] <= ~fillWay_i;
      end else if (hitStrobe_i) begin
        lruArr[lastIndex] <= ~hitWay_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validWay0_o <= 1'b0;
      validWay1_o <= 1'b0;
      lruWay_o <= 1'b0;
    end else if (rdEn_i) begin
      validWay0_o <= validArr[rdIndex_i][0];
      validWay1_o <= validArr[rdIndex_i][1];
      // a hit in this cycle has not reached lruArr yet
      if (hitStrobe_i && (lastIndex == rdIndex_i)) begin
        lruWay_o <= ~hitWay_i;
      end else begin
        lruWay_o <= lruArr[rdIndex_i];
      end
    end
  end

endmodule

// ==== design/cachePkg.sv ====
package cachePkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;

  // address fields: tag | index | offset
  localparam int OFFSET_W = 5;
  localparam int INDEX_W = 6;
  localparam int TAG_W = 21;
  localparam int INDEX_LSB = 5;
  localparam int TAG_LSB = 11;
  // offset bits above this pick the word in a line
  localparam int WORD_SEL_LSB = 3;

  // line and array geometry
  localparam int LINE_W = 256;
  localparam int BEATS = 4;
  localparam int SETS = 64;
  localparam int WAYS = 2;

  // lookup FSM encoding
  localparam logic [1:0] LK_IDLE = 2'd0;
  localparam logic [1:0] LK_COMPARE = 2'd1;
  localparam logic [1:0] LK_WAIT_FILL = 2'd2;

  // refill FSM encoding
  localparam logic [1:0] RF_IDLE = 2'd0;
  localparam logic [1:0] RF_REQUEST = 2'd1;
  localparam logic [1:0] RF_COLLECT = 2'd2;
  localparam logic [1:0] RF_WRITE = 2'd3;

endpackage
